// ==== hw/dbg_or1k_pkg.sv ====
// OR1K debug unit
// Shared types and constants

package dbg_or1k_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int DR_W = 53;  // Debug data register length

  typedef logic [31:0] word_t;     // Bus word, address or CRC
  typedef logic [15:0] count_t;    // Burst word count
  typedef logic [3:0]  opcode_t;   // Command field, register bits 51:48
  typedef logic [5:0]  bit_cnt_t;  // Bits shifted for the current word

  // Burst commands, bit 2 marks a read
  localparam opcode_t CMD_BWRITE32 = 4'h3;
  localparam opcode_t CMD_BREAD32  = 4'h7;

  ////////////////////////////////////////
  // FSM and TDO select
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    st_idle,
    st_rbegin,   // First read strobe
    st_rready,   // Wait for capture
    st_rstatus,  // Ready bit on TDO
    st_rburst,
    st_rcrc,
    st_wready,   // Wait for capture
    st_wwait,    // Wait for start bit
    st_wburst,
    st_wcrc,
    st_wmatch
  } burst_state_e;

  typedef enum logic [1:0] {
    tdo_ready,  // Bus unit ready bit
    tdo_data,   // Output shift register bit 0
    tdo_match,  // Write CRC match
    tdo_crc     // CRC serial out
  } tdo_sel_e;

  // Reflected CRC-32, LSB first
  localparam word_t CRC_POLY = 32'hedb8_8320;
  localparam word_t CRC_INIT = 32'hffff_ffff;

endpackage

// ==== hw/dbg_bus_req_if.sv ====
// Bus request between burst engine and bus unit
`timescale 1ns/1ns

interface dbg_bus_req_if;

  logic                strobe;  // One cycle, only while ready
  logic                rd_wrn;  // 1 read, 0 write
  dbg_or1k_pkg::word_t addr;
  dbg_or1k_pkg::word_t wdata;
  dbg_or1k_pkg::word_t rdata;   // Valid from ready until next strobe
  logic                ready;   // Bus unit idle

  // Burst engine side, FSM and datapath each drive their own part
  modport master (
    output strobe, rd_wrn, addr, wdata,
    input  rdata, ready
  );

  // Bus unit side
  modport slave (
    input  strobe, rd_wrn, addr, wdata,
    output rdata, ready
  );

endinterface

// ==== hw/dbg_crc32.sv ====
// Serial CRC-32
`timescale 1ns/1ns

module dbg_crc32 (
  input  logic                tck_i,
  input  logic                rst_i,
  input  logic                data_i,   // Bit entering the CRC
  input  logic                en_i,     // One CRC step
  input  logic                shift_i,  // Shift toward serial_o
  input  logic                clr_i,    // Restart at CRC_INIT
  input  dbg_or1k_pkg::word_t cmp_i,    // CRC sent by the host
  output logic                serial_o,
  output logic                match_o
);

  dbg_or1k_pkg::word_t crc_q;
  dbg_or1k_pkg::word_t crc_step;  // Value after one input bit

  // LSB first, feedback from bit 0
  always_comb begin
    crc_step = crc_q >> 1;
    if (crc_q[0] ^ data_i) begin
      crc_step = crc_step ^ dbg_or1k_pkg::CRC_POLY;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= dbg_or1k_pkg::CRC_INIT;
    end else if (clr_i) begin
      crc_q <= dbg_or1k_pkg::CRC_INIT;  // New command
    end else if (en_i) begin
      crc_q <= crc_step;
    end else if (shift_i) begin
      crc_q <= {1'b0, crc_q[31:1]};  // Own output shift register
    end
  end

  assign serial_o = crc_q[0];
  assign match_o  = (cmp_i == crc_q);

endmodule

// ==== hw/dbg_wb_master.sv ====
// Wishbone classic master, one transfer per strobe
`timescale 1ns/1ns

module dbg_wb_master (
  input  logic                tck_i,
  input  logic                rst_i,
  dbg_bus_req_if.slave        bus,
  output dbg_or1k_pkg::word_t wb_adr_o,
  output dbg_or1k_pkg::word_t wb_dat_o,
  input  dbg_or1k_pkg::word_t wb_dat_i,
  output logic                wb_we_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  input  logic                wb_ack_i
);

  logic cyc_q;  // Transfer in flight
  logic done;   // Ack of the current transfer

  assign done = cyc_q && wb_ack_i;

  ////////////////////////////////////////
  // Cycle control
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      cyc_q <= 1'b0;
    end else if (bus.strobe) begin
      cyc_q <= 1'b1;  // cyc and stb rise together
    end else if (done) begin
      cyc_q <= 1'b0;  // Low in the cycle after ack
    end
  end

  assign wb_cyc_o  = cyc_q;
  assign wb_stb_o  = cyc_q;
  assign bus.ready = ~cyc_q;  // High again the cycle after ack

  ////////////////////////////////////////
  // Request and read data
  ////////////////////////////////////////

  // Held stable until ack
  always_ff @(posedge tck_i) begin
    if (bus.strobe) begin
      wb_adr_o <= bus.addr;
      wb_dat_o <= bus.wdata;
      wb_we_o  <= ~bus.rd_wrn;
    end
  end

  always_ff @(posedge tck_i) begin
    if (done && !wb_we_o) begin
      bus.rdata <= wb_dat_i;  // Kept until the next strobe
    end
  end

endmodule

// ==== hw/dbg_burst_datapath.sv ====
// Burst counters, output shift register and TDO mux
`timescale 1ns/1ns

module dbg_burst_datapath #(
  parameter int unsigned ADDR_STEP = 1  // Address advance per word
) (
  input  logic                          tck_i,
  input  logic                          rst_i,
  input  logic                          tdi_i,
  input  logic [dbg_or1k_pkg::DR_W-1:0] data_register_i,
  input  logic                          addr_ld_i,
  input  logic                          addr_inc_i,
  input  logic                          word_ld_i,
  input  logic                          word_dec_i,
  input  logic                          bit_clr_i,
  input  logic                          bit_inc_i,
  input  logic                          opcode_ld_i,
  input  logic                          out_ld_i,
  input  logic                          out_shift_i,
  input  dbg_or1k_pkg::tdo_sel_e        tdo_sel_i,
  input  logic                          crc_serial_i,
  input  logic                          crc_match_i,
  dbg_bus_req_if.master                 bus,
  output logic                          module_tdo_o,
  output logic                          word_zero_o,
  output logic                          next_word_zero_o,
  output logic                          bit_max_o,    // 32nd bit of a word
  output logic                          bit_32_o,     // All CRC bits in
  output logic                          crc_rd_bit_o,
  output dbg_or1k_pkg::word_t           cmd_word_o    // CRC compare field
);

  dbg_or1k_pkg::word_t    addr_q;    // Address of the next transfer
  dbg_or1k_pkg::count_t   word_q;    // Words still to move
  dbg_or1k_pkg::bit_cnt_t bit_q;
  dbg_or1k_pkg::opcode_t  opcode_q;  // Latched command
  dbg_or1k_pkg::word_t    out_q;     // Read word, LSB leaves first

  // Address counter, old value goes out with the strobe
  always_ff @(posedge tck_i) begin
    if (addr_ld_i) begin
      addr_q <= data_register_i[47:16];
    end else if (addr_inc_i) begin
      addr_q <= addr_q + dbg_or1k_pkg::word_t'(ADDR_STEP);
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      word_q   <= '0;
      bit_q    <= '0;
      opcode_q <= '0;
    end else begin
      if (word_ld_i) begin
        word_q <= data_register_i[15:0];
      end else if (word_dec_i) begin
        word_q <= word_q - 1'b1;
      end
      if (bit_clr_i) begin
        bit_q <= '0;  // Clear wins over increment
      end else if (bit_inc_i) begin
        bit_q <= bit_q + 1'b1;
      end
      if (opcode_ld_i) begin
        opcode_q <= data_register_i[51:48];
      end
    end
  end

  // Output shift register
  always_ff @(posedge tck_i) begin
    if (out_ld_i) begin
      out_q <= bus.rdata;
    end else if (out_shift_i) begin
      out_q <= {1'b0, out_q[31:1]};
    end
  end

  assign word_zero_o      = (word_q == '0);
  assign next_word_zero_o = (word_q == dbg_or1k_pkg::count_t'(1));
  assign bit_max_o        = (bit_q == dbg_or1k_pkg::bit_cnt_t'(31));
  assign bit_32_o         = (bit_q == dbg_or1k_pkg::bit_cnt_t'(32));
  assign crc_rd_bit_o     = out_q[0];
  assign cmd_word_o       = data_register_i[52:21];

  // Bus request fields
  assign bus.addr   = addr_q;
  assign bus.rd_wrn = opcode_q[2];
  assign bus.wdata  = {tdi_i, data_register_i[52:22]};  // 32nd bit still on tdi

  // TDO mux
  always_comb begin
    unique case (tdo_sel_i)
      dbg_or1k_pkg::tdo_ready: module_tdo_o = bus.ready;
      dbg_or1k_pkg::tdo_data:  module_tdo_o = out_q[0];
      dbg_or1k_pkg::tdo_match: module_tdo_o = crc_match_i;
      default:                 module_tdo_o = crc_serial_i;
    endcase
  end

endmodule

// ==== hw/dbg_burst_fsm.sv ====
// Burst control FSM
`timescale 1ns/1ns

module dbg_burst_fsm (
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  logic                   capture_dr_i,
  input  logic                   shift_dr_i,
  input  logic                   update_dr_i,
  input  logic                   module_select_i,
  input  logic                   start_bit_i,       // Register bit 52
  input  dbg_or1k_pkg::opcode_t  opcode_i,          // Not yet latched
  input  logic                   word_zero_i,
  input  logic                   next_word_zero_i,
  input  logic                   bit_max_i,
  input  logic                   bit_32_i,
  dbg_bus_req_if.master          bus,
  output logic                   addr_ld_o,
  output logic                   addr_inc_o,
  output logic                   word_ld_o,
  output logic                   word_dec_o,
  output logic                   bit_clr_o,
  output logic                   bit_inc_o,
  output logic                   opcode_ld_o,
  output logic                   out_ld_o,
  output logic                   out_shift_o,
  output logic                   crc_en_o,
  output logic                   crc_clr_o,
  output logic                   crc_shift_en_o,
  output logic                   crc_in_sel_o,      // 1 tdi, 0 read data
  output dbg_or1k_pkg::tdo_sel_e tdo_sel_o,
  output logic                   top_inhibit_o
);

  dbg_or1k_pkg::burst_state_e state_q;
  dbg_or1k_pkg::burst_state_e state_d;
  logic burst_cmd;  // Burst command for this module
  logic shift;      // Shift cycle with module selected
  logic rd_next;    // Load next read word

  assign burst_cmd = module_select_i && update_dr_i && !start_bit_i &&
                     (opcode_i == dbg_or1k_pkg::CMD_BWRITE32 ||
                      opcode_i == dbg_or1k_pkg::CMD_BREAD32);
  assign shift = module_select_i && shift_dr_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= dbg_or1k_pkg::st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    addr_ld_o      = 1'b0;
    addr_inc_o     = 1'b0;
    word_ld_o      = 1'b0;
    word_dec_o     = 1'b0;
    bit_clr_o      = 1'b0;
    bit_inc_o      = 1'b0;
    opcode_ld_o    = 1'b0;
    out_ld_o       = 1'b0;
    out_shift_o    = 1'b0;
    crc_en_o       = 1'b0;
    crc_clr_o      = 1'b0;
    crc_shift_en_o = 1'b0;
    crc_in_sel_o   = 1'b0;
    tdo_sel_o      = dbg_or1k_pkg::tdo_data;
    top_inhibit_o  = 1'b0;
    bus.strobe     = 1'b0;
    rd_next        = 1'b0;

    unique case (state_q)
      dbg_or1k_pkg::st_idle: begin
        if (burst_cmd) begin  // Latch command, counters and CRC
          addr_ld_o   = 1'b1;
          word_ld_o   = 1'b1;
          bit_clr_o   = 1'b1;
          opcode_ld_o = 1'b1;
          crc_clr_o   = 1'b1;
          state_d     = opcode_i[2] ? dbg_or1k_pkg::st_rbegin : dbg_or1k_pkg::st_wready;
        end
      end
      dbg_or1k_pkg::st_rbegin: begin
        if (word_zero_i) begin
          state_d = dbg_or1k_pkg::st_idle;  // Empty burst, no bus cycle
        end else begin
          bus.strobe = 1'b1;  // First read
          addr_inc_o = 1'b1;
          state_d    = dbg_or1k_pkg::st_rready;
        end
      end
      dbg_or1k_pkg::st_rready: begin
        if (module_select_i && capture_dr_i) begin
          state_d = dbg_or1k_pkg::st_rstatus;
        end
      end
      dbg_or1k_pkg::st_rstatus: begin
        tdo_sel_o     = dbg_or1k_pkg::tdo_ready;  // Host polls this bit
        top_inhibit_o = 1'b1;
        if (shift && bus.ready) begin
          rd_next = 1'b1;
          state_d = dbg_or1k_pkg::st_rburst;
        end
      end
      dbg_or1k_pkg::st_rburst: begin
        top_inhibit_o = 1'b1;
        if (shift) begin
          out_shift_o = 1'b1;
          bit_inc_o   = 1'b1;
          crc_en_o    = 1'b1;  // CRC over the bit on TDO
          if (bit_max_i && word_zero_i) begin
            state_d = dbg_or1k_pkg::st_rcrc;
          end else if (bit_max_i) begin
            rd_next = 1'b1;
          end
        end
      end
      dbg_or1k_pkg::st_rcrc: begin
        tdo_sel_o      = dbg_or1k_pkg::tdo_crc;
        top_inhibit_o  = 1'b1;
        crc_shift_en_o = shift;  // Stays here until update
      end
      dbg_or1k_pkg::st_wready: begin
        if (word_zero_i) begin
          state_d = dbg_or1k_pkg::st_idle;
        end else if (module_select_i && capture_dr_i) begin
          state_d = dbg_or1k_pkg::st_wwait;
        end
      end
      dbg_or1k_pkg::st_wwait: begin
        top_inhibit_o = 1'b1;
        if (shift && start_bit_i) begin
          // tdi already holds the first data bit
          bit_inc_o    = 1'b1;
          word_dec_o   = 1'b1;  // Count ahead by one word
          crc_en_o     = 1'b1;
          crc_in_sel_o = 1'b1;
          state_d      = dbg_or1k_pkg::st_wburst;
        end
      end
      dbg_or1k_pkg::st_wburst: begin
        top_inhibit_o = 1'b1;
        if (shift) begin
          bit_inc_o    = 1'b1;
          crc_en_o     = 1'b1;
          crc_in_sel_o = 1'b1;
          if (bit_max_i) begin  // Word complete, write it
            bit_clr_o  = 1'b1;
            bus.strobe = 1'b1;
            addr_inc_o = 1'b1;
            word_dec_o = 1'b1;
            if (word_zero_i) begin
              state_d = dbg_or1k_pkg::st_wcrc;
            end
          end
        end
      end
      dbg_or1k_pkg::st_wcrc: begin
        top_inhibit_o = 1'b1;
        bit_inc_o     = shift;  // Host CRC enters the register
        if (bit_32_i) begin
          tdo_sel_o = dbg_or1k_pkg::tdo_match;
          state_d   = dbg_or1k_pkg::st_wmatch;
        end
      end
      dbg_or1k_pkg::st_wmatch: begin
        tdo_sel_o     = dbg_or1k_pkg::tdo_match;
        top_inhibit_o = 1'b1;
      end
      default: begin
        state_d = dbg_or1k_pkg::st_idle;
      end
    endcase

    // Next read word to the shift register, prefetch the one after
    if (rd_next) begin
      out_ld_o   = 1'b1;
      bit_clr_o  = 1'b1;
      word_dec_o = 1'b1;
      if (!next_word_zero_i) begin
        bus.strobe = 1'b1;
        addr_inc_o = 1'b1;
      end
    end

    // Early termination from any burst state
    if (update_dr_i && state_q != dbg_or1k_pkg::st_idle) begin
      state_d = dbg_or1k_pkg::st_idle;
    end
  end

endmodule

// ==== hw/dbg_or1k_module.sv ====
// OR1K debug unit, burst access over Wishbone
`timescale 1ns/1ns

module dbg_or1k_module #(
  parameter int unsigned ADDR_STEP = 1  // SPR bus is word addressed
) (
  input  logic                          tck_i,
  input  logic                          rst_i,
  input  logic                          tdi_i,
  output logic                          module_tdo_o,
  input  logic                          capture_dr_i,
  input  logic                          shift_dr_i,
  input  logic                          update_dr_i,
  input  logic [dbg_or1k_pkg::DR_W-1:0] data_register_i,
  input  logic                          module_select_i,
  output logic                          top_inhibit_o,
  output dbg_or1k_pkg::word_t           wb_adr_o,
  output dbg_or1k_pkg::word_t           wb_dat_o,
  input  dbg_or1k_pkg::word_t           wb_dat_i,
  output logic                          wb_we_o,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  input  logic                          wb_ack_i
);

  // FSM to datapath
  logic addr_ld;
  logic addr_inc;
  logic word_ld;
  logic word_dec;
  logic bit_clr;
  logic bit_inc;
  logic opcode_ld;
  logic out_ld;
  logic out_shift;
  dbg_or1k_pkg::tdo_sel_e tdo_sel;

  // CRC control and status
  logic crc_en;
  logic crc_clr;
  logic crc_shift_en;
  logic crc_in_sel;
  logic crc_rd_bit;
  logic crc_serial;
  logic crc_match;
  dbg_or1k_pkg::word_t cmd_word;

  // Datapath status
  logic word_zero;
  logic next_word_zero;
  logic bit_max;
  logic bit_32;

  // Write data from tdi, read data from the shift register
  logic crc_data;
  assign crc_data = crc_in_sel ? tdi_i : crc_rd_bit;

  dbg_bus_req_if bus ();

  dbg_burst_fsm u_fsm (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .module_select_i (module_select_i),
    .start_bit_i     (data_register_i[52]),
    .opcode_i        (data_register_i[51:48]),
    .word_zero_i     (word_zero),
    .next_word_zero_i(next_word_zero),
    .bit_max_i       (bit_max),
    .bit_32_i        (bit_32),
    .bus             (bus.master),
    .addr_ld_o       (addr_ld),
    .addr_inc_o      (addr_inc),
    .word_ld_o       (word_ld),
    .word_dec_o      (word_dec),
    .bit_clr_o       (bit_clr),
    .bit_inc_o       (bit_inc),
    .opcode_ld_o     (opcode_ld),
    .out_ld_o        (out_ld),
    .out_shift_o     (out_shift),
    .crc_en_o        (crc_en),
    .crc_clr_o       (crc_clr),
    .crc_shift_en_o  (crc_shift_en),
    .crc_in_sel_o    (crc_in_sel),
    .tdo_sel_o       (tdo_sel),
    .top_inhibit_o   (top_inhibit_o)
  );

  dbg_burst_datapath #(
    .ADDR_STEP(ADDR_STEP)
  ) u_datapath (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi_i),
    .data_register_i (data_register_i),
    .addr_ld_i       (addr_ld),
    .addr_inc_i      (addr_inc),
    .word_ld_i       (word_ld),
    .word_dec_i      (word_dec),
    .bit_clr_i       (bit_clr),
    .bit_inc_i       (bit_inc),
    .opcode_ld_i     (opcode_ld),
    .out_ld_i        (out_ld),
    .out_shift_i     (out_shift),
    .tdo_sel_i       (tdo_sel),
    .crc_serial_i    (crc_serial),
    .crc_match_i     (crc_match),
    .bus             (bus.master),
    .module_tdo_o    (module_tdo_o),
    .word_zero_o     (word_zero),
    .next_word_zero_o(next_word_zero),
    .bit_max_o       (bit_max),
    .bit_32_o        (bit_32),
    .crc_rd_bit_o    (crc_rd_bit),
    .cmd_word_o      (cmd_word)
  );

  dbg_crc32 u_crc (
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .data_i  (crc_data),
    .en_i    (crc_en),
    .shift_i (crc_shift_en),
    .clr_i   (crc_clr),
    .cmp_i   (cmd_word),
    .serial_o(crc_serial),
    .match_o (crc_match)
  );

  dbg_wb_master u_wb (
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .bus     (bus.slave),
    .wb_adr_o(wb_adr_o),
    .wb_dat_o(wb_dat_o),
    .wb_dat_i(wb_dat_i),
    .wb_we_o (wb_we_o),
    .wb_cyc_o(wb_cyc_o),
    .wb_stb_o(wb_stb_o),
    .wb_ack_i(wb_ack_i)
  );

endmodule

// ==== testbench/dbg_or1k_checker.sv ====
// Wishbone master protocol checks
`timescale 1ns/1ns

module dbg_or1k_checker (
  input logic                tck_i,
  input logic                rst_i,
  input logic                strobe_i,  // Request from burst engine
  input logic                ready_i,
  input logic                wb_cyc_i,
  input logic                wb_stb_i,
  input logic                wb_ack_i,
  input logic                wb_we_i,
  input dbg_or1k_pkg::word_t wb_adr_i,
  input dbg_or1k_pkg::word_t wb_dat_i
);

  ////////////////////////////////////////
  // Wishbone classic rules
  ////////////////////////////////////////

  // cyc and stb rise together, one cycle after the request
  a_stb_cyc: assert property (@(posedge tck_i) disable iff (rst_i)
    strobe_i |=> wb_cyc_i && wb_stb_i)
    else $error("cyc or stb missing after strobe");

  // Request held until ack
  a_stable: assert property (@(posedge tck_i) disable iff (rst_i)
    wb_stb_i && !wb_ack_i |=> $stable(wb_adr_i) && $stable(wb_dat_i) && $stable(wb_we_i))
    else $error("address or data changed while waiting for ack");

  a_cyc_drop: assert property (@(posedge tck_i) disable iff (rst_i)
    wb_cyc_i && wb_ack_i |=> !wb_cyc_i)
    else $error("cyc still high after ack");

  // Request side, write timing relies on this
  a_strobe_ready: assert property (@(posedge tck_i) disable iff (rst_i)
    strobe_i |-> ready_i)
    else $error("strobe while bus unit busy");

endmodule

bind dbg_wb_master dbg_or1k_checker u_checker (
  .tck_i   (tck_i),
  .rst_i   (rst_i),
  .strobe_i(bus.strobe),
  .ready_i (bus.ready),
  .wb_cyc_i(wb_cyc_o),
  .wb_stb_i(wb_stb_o),
  .wb_ack_i(wb_ack_i),
  .wb_we_i (wb_we_o),
  .wb_adr_i(wb_adr_o),
  .wb_dat_i(wb_dat_o)
);

// ==== testbench/tb_dbg_or1k.sv ====
// OR1K debug unit testbench
`timescale 1ns/1ns

module tb_dbg_or1k;

  localparam int unsigned ADDR_STEP      = 1;
  localparam int          TIMEOUT_CYCLES = 20000;  // All tests take a few thousand
  localparam int          POLL_LIMIT     = 200;

  logic                tck_i;
  logic                rst_i;
  logic                tdi_i;
  logic                capture_dr_i;
  logic                shift_dr_i;
  logic                update_dr_i;
  logic                module_select_i;
  logic [52:0]         data_register_i = '0;
  logic                module_tdo_o;
  logic                top_inhibit_o;
  dbg_or1k_pkg::word_t wb_adr_o;
  dbg_or1k_pkg::word_t wb_dat_o;
  dbg_or1k_pkg::word_t wb_dat_i = '0;
  logic                wb_we_o;
  logic                wb_cyc_o;
  logic                wb_stb_o;
  logic                wb_ack_i = 1'b0;

  logic [52:0]         dr_q = '0;     // TAP data register
  dbg_or1k_pkg::word_t mem [256];     // Wishbone slave memory
  dbg_or1k_pkg::word_t wlog_addr [$]; // Slave write log
  dbg_or1k_pkg::word_t wlog_data [$];
  dbg_or1k_pkg::word_t wbuf [16];
  dbg_or1k_pkg::word_t rbuf [16];
  logic                busy = 1'b0;   // Slave inside a transfer
  int                  wait_cnt = 0;
  int                  bus_starts = 0;
  int                  cycles = 0;
  int                  checks = 0;
  int                  errors = 0;
  logic                inhibit_seen;

  dbg_or1k_module #(
    .ADDR_STEP(ADDR_STEP)
  ) uut (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .module_tdo_o   (module_tdo_o),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .data_register_i(data_register_i),
    .module_select_i(module_select_i),
    .top_inhibit_o  (top_inhibit_o),
    .wb_adr_o       (wb_adr_o),
    .wb_dat_o       (wb_dat_o),
    .wb_dat_i       (wb_dat_i),
    .wb_we_o        (wb_we_o),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_ack_i       (wb_ack_i)
  );

  always #4 tck_i = ~tck_i;

  ////////////////////////////////////////
  // TAP and Wishbone models
  ////////////////////////////////////////

  // Shift at the rising edge, DUT sees the register from the falling edge on
  always @(posedge tck_i) if (shift_dr_i) dr_q <= {tdi_i, dr_q[52:1]};
  always @(negedge tck_i) data_register_i <= dr_q;

  // Slave with random wait states
  always @(negedge tck_i) begin
    if (wb_ack_i) begin
      wb_ack_i = 1'b0;  // Single-cycle ack
      busy     = 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!busy) begin
        busy       = 1'b1;
        bus_starts = bus_starts + 1;
        wait_cnt   = $urandom_range(7, 0);
      end
      if (wait_cnt == 0) begin
        wb_ack_i = 1'b1;
        if (wb_we_o) begin
          mem[wb_adr_o[7:0]] = wb_dat_o;
          wlog_addr.push_back(wb_adr_o);
          wlog_data.push_back(wb_dat_o);
        end else begin
          wb_dat_i = mem[wb_adr_o[7:0]];
        end
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

  always @(posedge tck_i) begin
    cycles = cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_eq(input dbg_or1k_pkg::word_t got, input dbg_or1k_pkg::word_t exp,
                          input string msg);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // Reflected CRC-32, one input bit
  function automatic dbg_or1k_pkg::word_t crc_next(input dbg_or1k_pkg::word_t c, input logic b);
    if (c[0] ^ b) return (c >> 1) ^ dbg_or1k_pkg::CRC_POLY;
    return c >> 1;
  endfunction

  // One TCK cycle, TDO sampled before the rising edge
  task automatic jtag_cycle(input logic cap, input logic shf, input logic upd,
                            input logic din, output logic dout);
    @(negedge tck_i);
    capture_dr_i = cap;
    shift_dr_i   = shf;
    update_dr_i  = upd;
    tdi_i        = din;
    #2;
    dout         = module_tdo_o;
    inhibit_seen = top_inhibit_o;
  endtask

  task automatic send_command(input dbg_or1k_pkg::opcode_t op, input dbg_or1k_pkg::word_t addr,
                              input dbg_or1k_pkg::count_t cnt);
    logic [52:0] cmd;
    logic        t;
    cmd = {1'b0, op, addr, cnt};
    jtag_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    for (int i = 0; i < 53; i++) jtag_cycle(1'b0, 1'b1, 1'b0, cmd[i], t);
    jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);  // Select-DR
  endtask

  // Capture, then shift until the ready bit shows
  task automatic poll_status(output logic ok);
    logic t;
    int   polls;
    t     = 1'b0;
    polls = 0;
    jtag_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    t = 1'b0;
    while (t !== 1'b1 && polls < POLL_LIMIT) begin
      jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, t);
      polls = polls + 1;
    end
    ok = (t === 1'b1);
    if (!ok) begin
      errors = errors + 1;
      $display("Read status bit never went high after %0d polls", POLL_LIMIT);
    end
  endtask

  task automatic write_burst(input dbg_or1k_pkg::word_t addr, input int n, input logic flip,
                             output logic match);
    dbg_or1k_pkg::word_t crc;
    logic                t;
    crc = dbg_or1k_pkg::CRC_INIT;
    send_command(dbg_or1k_pkg::CMD_BWRITE32, addr, dbg_or1k_pkg::count_t'(n));
    jtag_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    jtag_cycle(1'b0, 1'b1, 1'b0, 1'b1, t);  // Start bit
    for (int k = 0; k < n; k++) begin
      for (int b = 0; b < 32; b++) begin
        jtag_cycle(1'b0, 1'b1, 1'b0, wbuf[k][b], t);
        crc = crc_next(crc, wbuf[k][b]);
      end
    end
    if (flip) crc[5] = ~crc[5];
    for (int b = 0; b < 32; b++) jtag_cycle(1'b0, 1'b1, 1'b0, crc[b], t);
    jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, match);  // Match bit on TDO
    jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
  endtask

  task automatic read_burst(input dbg_or1k_pkg::word_t addr, input int n,
                            output dbg_or1k_pkg::word_t crc_got);
    logic ok;
    logic t;
    crc_got = '0;
    send_command(dbg_or1k_pkg::CMD_BREAD32, addr, dbg_or1k_pkg::count_t'(n));
    poll_status(ok);
    if (ok) begin
      for (int k = 0; k < n; k++) begin
        for (int b = 0; b < 32; b++) begin
          jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, t);
          rbuf[k][b] = t;
        end
      end
      for (int b = 0; b < 32; b++) begin
        jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, t);
        crc_got[b] = t;
      end
    end
    jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
  endtask

  task automatic wait_bus_idle();
    int n;
    n = 0;
    while (wb_cyc_o && n < 100) begin
      @(negedge tck_i);
      n = n + 1;
    end
    if (wb_cyc_o) begin
      errors = errors + 1;
      $display("Wishbone cycle never completed");
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_burst_write();
    logic match;
    wlog_addr.delete();
    wlog_data.delete();
    for (int k = 0; k < 4; k++) wbuf[k] = $urandom;
    write_burst(32'h10, 4, 1'b0, match);
    wait_bus_idle();
    check_eq(wlog_addr.size(), 4, "write count");
    for (int k = 0; k < 4 && k < wlog_addr.size(); k++) begin
      check_eq(wlog_addr[k], 32'h10 + k * ADDR_STEP, "write address");
      check_eq(wlog_data[k], wbuf[k], "write data");
    end
  endtask

  task automatic test_write_crc();
    logic match;
    for (int k = 0; k < 3; k++) wbuf[k] = $urandom;
    write_burst(32'h20, 3, 1'b0, match);
    check_eq(match, 1, "match bit, good CRC");
    write_burst(32'h20, 3, 1'b1, match);
    check_eq(match, 0, "match bit, flipped CRC");
    wait_bus_idle();
  endtask

  // Data and CRC of a read against memory
  task automatic test_read(input dbg_or1k_pkg::word_t addr, input int n);
    dbg_or1k_pkg::word_t crc_got;
    dbg_or1k_pkg::word_t crc_exp;
    dbg_or1k_pkg::word_t exp;
    crc_exp = dbg_or1k_pkg::CRC_INIT;
    read_burst(addr, n, crc_got);
    for (int k = 0; k < n; k++) begin
      exp = mem[8'(addr + k * ADDR_STEP)];
      check_eq(rbuf[k], exp, "read data");
      for (int b = 0; b < 32; b++) crc_exp = crc_next(crc_exp, exp[b]);
    end
    check_eq(crc_got, crc_exp, "read CRC");
    wait_bus_idle();
  endtask

  task automatic test_zero_and_abort();
    int   starts;
    logic t;
    logic ok;
    starts = bus_starts;
    send_command(dbg_or1k_pkg::CMD_BWRITE32, 32'h30, 16'd0);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
    check_eq(uut.u_fsm.state_q, dbg_or1k_pkg::st_idle, "state after zero write");
    send_command(dbg_or1k_pkg::CMD_BREAD32, 32'h30, 16'd0);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
    check_eq(uut.u_fsm.state_q, dbg_or1k_pkg::st_idle, "state after zero read");
    check_eq(bus_starts, starts, "bus cycles for zero count");
    // Write stopped inside the first word
    send_command(dbg_or1k_pkg::CMD_BWRITE32, 32'h30, 16'd2);
    jtag_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    for (int b = 0; b < 11; b++) jtag_cycle(1'b0, 1'b1, 1'b0, b == 0, t);
    check_eq(inhibit_seen, 1, "inhibit during write");
    jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
    check_eq(inhibit_seen, 0, "inhibit after write abort");
    check_eq(uut.u_fsm.state_q, dbg_or1k_pkg::st_idle, "state after write abort");
    // Read stopped in the second word
    send_command(dbg_or1k_pkg::CMD_BREAD32, 32'h50, 16'd4);
    poll_status(ok);
    for (int b = 0; b < 40; b++) jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, t);
    check_eq(inhibit_seen, 1, "inhibit during read");
    jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
    check_eq(inhibit_seen, 0, "inhibit after read abort");
    check_eq(uut.u_fsm.state_q, dbg_or1k_pkg::st_idle, "state after read abort");
    wait_bus_idle();
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(56));
    tck_i           = 1'b0;
    rst_i           = 1'b1;
    tdi_i           = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b1;
    // Pattern over the whole address
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i) ^ 8'h5a, 8'(i * 3), ~8'(i), 8'(i)};
    end
    repeat (8) @(posedge tck_i);
    @(negedge tck_i);
    rst_i = 1'b0;

    test_burst_write();
    test_write_crc();
    test_read(32'h40, 5);
    test_read(32'h80, 8);   // Random ack delays, status polled
    test_zero_and_abort();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== dbg_or1k.f ====
hw/dbg_or1k_pkg.sv
hw/dbg_bus_req_if.sv
hw/dbg_crc32.sv
hw/dbg_wb_master.sv
hw/dbg_burst_datapath.sv
hw/dbg_burst_fsm.sv
hw/dbg_or1k_module.sv
testbench/dbg_or1k_checker.sv
testbench/tb_dbg_or1k.sv

// ==== Makefile ====
# Verilator build and run for the OR1K debug unit

VERILATOR ?= verilator
TOP       ?= tb_dbg_or1k
RTL_TOP   ?= dbg_or1k_module
FLIST     ?= dbg_or1k.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
